/* rtl/muldiv_pkg.sv */
package muldiv_pkg;

    localparam int XLEN = 32;
    // one quotient bit per iteration
    localparam int DIV_CYCLES = 32;
    localparam int DIV_CNT_W = $clog2(DIV_CYCLES + 1);

    typedef logic [XLEN-1:0] word_t;
    typedef logic [DIV_CNT_W-1:0] div_cnt_t;

    // OP_NOP must stay zero, a cleared payload is a bubble
    typedef enum logic [3:0] {
        OP_NOP   = 4'd0,
        OP_MULT  = 4'd1,
        OP_MULTU = 4'd2,
        OP_DIV   = 4'd3,
        OP_DIVU  = 4'd4,
        OP_MTHI  = 4'd5,
        OP_MTLO  = 4'd6,
        OP_MFHI  = 4'd7,
        OP_MFLO  = 4'd8
    } muldiv_op_e;

    // bit 1 writes HI, bit 0 writes LO
    typedef logic [1:0] hilo_we_t;

    typedef struct packed {
        muldiv_op_e op;
        word_t      a;
        word_t      b;
    } issue_t;

    typedef struct packed {
        hilo_we_t hilo_we;
        word_t    hi;
        word_t    lo;
        logic     rd_valid;
        word_t    rd_data;
    } wb_t;

endpackage

/* rtl/stage_reg.sv */
`timescale 1ns/1ps

module stage_reg #(
    parameter type T = logic
) (
    input  logic clk,
    input  logic arst_n_i,
    input  logic hold_i,
    input  logic bubble_i,
    input  T     d_i,
    output T     q_o
);

    // hold wins over bubble, a held stage keeps its op
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            q_o <= '0;
        end else if (!hold_i) begin
            if (bubble_i) begin
                q_o <= '0;
            end else begin
                q_o <= d_i;
            end
        end
    end

endmodule

/* rtl/pipe_control.sv */
`timescale 1ns/1ps

module pipe_control (
    input  logic clk,
    input  logic arst_n_i,
    input  logic div_req_i,
    input  logic div_done_i,
    output logic div_start_o,
    output logic stall_o,
    output logic ex_bubble_o
);

    typedef enum logic {
        IDLE = 1'b0,
        BUSY = 1'b1
    } state_e;

    state_e state;
    state_e state_nxt;
    logic   div_pending;

    // start only from IDLE, so a held divide is launched once
    assign div_start_o = (state == IDLE) && div_req_i;

    // pending from the start cycle up to, not including, the done cycle
    assign div_pending = div_start_o || ((state == BUSY) && !div_done_i);

    assign stall_o = div_pending;

    // nothing valid leaves execute while the divider runs
    assign ex_bubble_o = div_pending;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (div_req_i) begin
                    state_nxt = BUSY;
                end
            end
            BUSY: begin
                if (div_done_i) begin
                    state_nxt = IDLE;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

endmodule

/* rtl/ex_stage.sv */
`timescale 1ns/1ps

module ex_stage (
    input  muldiv_pkg::issue_t issue_i,
    input  muldiv_pkg::wb_t    wb_i,
    input  muldiv_pkg::word_t  hi_i,
    input  muldiv_pkg::word_t  lo_i,
    input  muldiv_pkg::word_t  div_quot_i,
    input  muldiv_pkg::word_t  div_rem_i,
    output muldiv_pkg::wb_t    wb_o,
    output logic               div_req_o,
    output logic               div_signed_o,
    output muldiv_pkg::word_t  div_dividend_o,
    output muldiv_pkg::word_t  div_divisor_o
);

    muldiv_pkg::muldiv_op_e              op;
    logic                                mul_signed;
    logic signed [muldiv_pkg::XLEN:0]     mul_a;
    logic signed [muldiv_pkg::XLEN:0]     mul_b;
    logic signed [2*muldiv_pkg::XLEN+1:0] product;
    muldiv_pkg::word_t                   fwd_hi;
    muldiv_pkg::word_t                   fwd_lo;

    assign op = issue_i.op;

    // one 33x33 signed multiplier covers MULT and MULTU
    assign mul_signed = (op == muldiv_pkg::OP_MULT);
    assign mul_a      = {mul_signed & issue_i.a[muldiv_pkg::XLEN-1], issue_i.a};
    assign mul_b      = {mul_signed & issue_i.b[muldiv_pkg::XLEN-1], issue_i.b};
    assign product    = mul_a * mul_b;

    // uncommitted write in the wb register is newer than HI/LO
    assign fwd_hi = wb_i.hilo_we[1] ? wb_i.hi : hi_i;
    assign fwd_lo = wb_i.hilo_we[0] ? wb_i.lo : lo_i;

    assign div_req_o      = (op == muldiv_pkg::OP_DIV) || (op == muldiv_pkg::OP_DIVU);
    assign div_signed_o   = (op == muldiv_pkg::OP_DIV);
    assign div_dividend_o = issue_i.a;
    assign div_divisor_o  = issue_i.b;

    always_comb begin
        wb_o = '0;
        case (op)
            muldiv_pkg::OP_MULT,
            muldiv_pkg::OP_MULTU: begin
                wb_o.hilo_we = 2'b11;
                wb_o.hi      = product[2*muldiv_pkg::XLEN-1:muldiv_pkg::XLEN];
                wb_o.lo      = product[muldiv_pkg::XLEN-1:0];
            end
            // only taken by u_wb in the done cycle
            muldiv_pkg::OP_DIV,
            muldiv_pkg::OP_DIVU: begin
                wb_o.hilo_we = 2'b11;
                wb_o.hi      = div_rem_i;
                wb_o.lo      = div_quot_i;
            end
            muldiv_pkg::OP_MTHI: begin
                wb_o.hilo_we = 2'b10;
                wb_o.hi      = issue_i.a;
            end
            muldiv_pkg::OP_MTLO: begin
                wb_o.hilo_we = 2'b01;
                wb_o.lo      = issue_i.a;
            end
            muldiv_pkg::OP_MFHI: begin
                wb_o.rd_valid = 1'b1;
                wb_o.rd_data  = fwd_hi;
            end
            muldiv_pkg::OP_MFLO: begin
                wb_o.rd_valid = 1'b1;
                wb_o.rd_data  = fwd_lo;
            end
            default: begin
                wb_o = '0;
            end
        endcase
    end

endmodule

/* rtl/div_unit.sv */
`timescale 1ns/1ps

module div_unit (
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic              start_i,
    input  logic              signed_i,
    input  muldiv_pkg::word_t dividend_i,
    input  muldiv_pkg::word_t divisor_i,
    output muldiv_pkg::word_t quot_o,
    output muldiv_pkg::word_t rem_o,
    output logic              done_o
);

    logic                        busy;
    logic                        load;
    muldiv_pkg::div_cnt_t        cnt;
    logic                        neg_q;
    logic                        neg_r;
    logic                        dvs_zero;
    muldiv_pkg::word_t           dvs_r;
    muldiv_pkg::word_t           quo_r;
    muldiv_pkg::word_t           rem_r;
    muldiv_pkg::word_t           a_mag;
    muldiv_pkg::word_t           b_mag;
    logic [muldiv_pkg::XLEN:0]   shifted;
    logic [muldiv_pkg::XLEN:0]   diff;

    assign load = start_i && !busy;

    assign a_mag = (signed_i && dividend_i[muldiv_pkg::XLEN-1]) ? -dividend_i : dividend_i;
    assign b_mag = (signed_i && divisor_i[muldiv_pkg::XLEN-1]) ? -divisor_i : divisor_i;

    // partial remainder takes the next dividend bit from the top of quo_r
    assign shifted = {rem_r, quo_r[muldiv_pkg::XLEN-1]};
    assign diff    = shifted - {1'b0, dvs_r};

    // cnt runs DIV_CYCLES steps, the zero count is the sign fix-up cycle
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy   <= 1'b0;
            cnt    <= '0;
            done_o <= 1'b0;
        end else begin
            done_o <= 1'b0;
            if (load) begin
                busy <= 1'b1;
                cnt  <= muldiv_pkg::div_cnt_t'(muldiv_pkg::DIV_CYCLES);
            end else if (busy) begin
                if (cnt != '0) begin
                    cnt <= cnt - 1'b1;
                end else begin
                    busy   <= 1'b0;
                    done_o <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            quo_r    <= a_mag;
            rem_r    <= '0;
            dvs_r    <= b_mag;
            neg_q    <= signed_i & (dividend_i[muldiv_pkg::XLEN-1] ^ divisor_i[muldiv_pkg::XLEN-1]);
            neg_r    <= signed_i & dividend_i[muldiv_pkg::XLEN-1];
            dvs_zero <= (divisor_i == '0);
        end else if (busy && (cnt != '0)) begin
            // restore by keeping the shifted value when the trial goes negative
            if (!diff[muldiv_pkg::XLEN]) begin
                rem_r <= diff[muldiv_pkg::XLEN-1:0];
                quo_r <= {quo_r[muldiv_pkg::XLEN-2:0], 1'b1};
            end else begin
                rem_r <= shifted[muldiv_pkg::XLEN-1:0];
                quo_r <= {quo_r[muldiv_pkg::XLEN-2:0], 1'b0};
            end
        end else if (busy) begin
            // a zero divisor leaves |dividend| in rem_r, so only the quotient is forced
            quot_o <= dvs_zero ? '1 : (neg_q ? -quo_r : quo_r);
            rem_o  <= neg_r ? -rem_r : rem_r;
        end
    end

endmodule

/* rtl/hilo_regs.sv */
`timescale 1ns/1ps

module hilo_regs (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  muldiv_pkg::hilo_we_t we_i,
    input  muldiv_pkg::word_t    hi_i,
    input  muldiv_pkg::word_t    lo_i,
    output muldiv_pkg::word_t    hi_o,
    output muldiv_pkg::word_t    lo_o
);

    // halves are written independently
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            hi_o <= '0;
            lo_o <= '0;
        end else begin
            if (we_i[1]) begin
                hi_o <= hi_i;
            end
            if (we_i[0]) begin
                lo_o <= lo_i;
            end
        end
    end

endmodule

/* rtl/muldiv_top.sv */
`timescale 1ns/1ps

module muldiv_top (
    input  logic                   clk,
    input  logic                   arst_n_i,
    input  logic                   op_valid_i,
    input  muldiv_pkg::muldiv_op_e op_i,
    input  muldiv_pkg::word_t      opnd_a_i,
    input  muldiv_pkg::word_t      opnd_b_i,
    output logic                   stall_o,
    output logic                   rd_valid_o,
    output muldiv_pkg::word_t      rd_data_o,
    output muldiv_pkg::word_t      hi_o,
    output muldiv_pkg::word_t      lo_o
);

    muldiv_pkg::issue_t issue_d;
    muldiv_pkg::issue_t issue_q;
    muldiv_pkg::wb_t    ex_wb;
    muldiv_pkg::wb_t    wb_q;
    muldiv_pkg::word_t  hi_q;
    muldiv_pkg::word_t  lo_q;
    muldiv_pkg::word_t  div_dividend;
    muldiv_pkg::word_t  div_divisor;
    muldiv_pkg::word_t  div_quot;
    muldiv_pkg::word_t  div_rem;
    logic               div_req;
    logic               div_signed;
    logic               div_start;
    logic               div_done;
    logic               stall;
    logic               ex_bubble;

    // invalid input cycles enter as NOP
    assign issue_d = op_valid_i ? '{op: op_i, a: opnd_a_i, b: opnd_b_i} : '0;

    assign stall_o    = stall;
    assign rd_valid_o = wb_q.rd_valid;
    assign rd_data_o  = wb_q.rd_data;
    assign hi_o       = hi_q;
    assign lo_o       = lo_q;

    pipe_control u_ctrl (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .div_req_i   (div_req),
        .div_done_i  (div_done),
        .div_start_o (div_start),
        .stall_o     (stall),
        .ex_bubble_o (ex_bubble)
    );

    stage_reg #(.T(muldiv_pkg::issue_t)) u_issue (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .hold_i   (stall),
        .bubble_i (1'b0),
        .d_i      (issue_d),
        .q_o      (issue_q)
    );

    ex_stage u_ex (
        .issue_i        (issue_q),
        .wb_i           (wb_q),
        .hi_i           (hi_q),
        .lo_i           (lo_q),
        .div_quot_i     (div_quot),
        .div_rem_i      (div_rem),
        .wb_o           (ex_wb),
        .div_req_o      (div_req),
        .div_signed_o   (div_signed),
        .div_dividend_o (div_dividend),
        .div_divisor_o  (div_divisor)
    );

    div_unit u_div (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .start_i    (div_start),
        .signed_i   (div_signed),
        .dividend_i (div_dividend),
        .divisor_i  (div_divisor),
        .quot_o     (div_quot),
        .rem_o      (div_rem),
        .done_o     (div_done)
    );

    stage_reg #(.T(muldiv_pkg::wb_t)) u_wb (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .hold_i   (1'b0),
        .bubble_i (ex_bubble),
        .d_i      (ex_wb),
        .q_o      (wb_q)
    );

    hilo_regs u_hilo (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .we_i     (wb_q.hilo_we),
        .hi_i     (wb_q.hi),
        .lo_i     (wb_q.lo),
        .hi_o     (hi_q),
        .lo_o     (lo_q)
    );

endmodule

/* sim/muldiv_properties.sv */
`timescale 1ns/1ps

module muldiv_properties (
    input logic clk,
    input logic arst_n_i,
    input logic stall_i,
    input logic div_req_i,
    input logic div_done_i,
    input logic rd_valid_i
);

    // stall only while a divide sits in execute
    stall_needs_div: assert property (
        @(posedge clk) disable iff (!arst_n_i) stall_i |-> div_req_i
    ) else $error("stall_o high without a divide in execute");

    // divide result enters wb at the end of the done cycle
    no_rd_with_div: assert property (
        @(posedge clk) disable iff (!arst_n_i) div_done_i |=> !rd_valid_i
    ) else $error("rd_valid_o set together with a divide result");

    done_drops_stall: assert property (
        @(posedge clk) disable iff (!arst_n_i) div_done_i |-> $fell(stall_i)
    ) else $error("stall_o did not fall in the divider done cycle");

endmodule

bind muldiv_top muldiv_properties u_props (
    .clk        (clk),
    .arst_n_i   (arst_n_i),
    .stall_i    (stall),
    .div_req_i  (div_req),
    .div_done_i (div_done),
    .rd_valid_i (rd_valid_o)
);

/* sim/tb_muldiv.sv */
`timescale 1ns/1ps

module tb_muldiv;

    logic                   clk;
    logic                   arst_n_i;
    logic                   op_valid_i;
    muldiv_pkg::muldiv_op_e op_i;
    muldiv_pkg::word_t      opnd_a_i;
    muldiv_pkg::word_t      opnd_b_i;
    logic                   stall_o;
    logic                   rd_valid_o;
    muldiv_pkg::word_t      rd_data_o;
    muldiv_pkg::word_t      hi_o;
    muldiv_pkg::word_t      lo_o;

    // stimulus table with one column per queue
    muldiv_pkg::muldiv_op_e tbl_op[$];
    muldiv_pkg::word_t      tbl_a[$];
    muldiv_pkg::word_t      tbl_b[$];
    muldiv_pkg::word_t      tbl_hi[$];
    muldiv_pkg::word_t      tbl_lo[$];
    muldiv_pkg::word_t      tbl_rd[$];

    // expected values keyed by the cycle they become visible
    muldiv_pkg::word_t      exp_rd[int];
    muldiv_pkg::word_t      exp_hi[int];
    muldiv_pkg::word_t      exp_lo[int];

    muldiv_pkg::word_t      model_hi = '0;
    muldiv_pkg::word_t      model_lo = '0;
    int                     cyc = 0;
    logic                   checking = 1'b0;
    logic                   table_ready = 1'b0;

    muldiv_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    function automatic logic is_div(input muldiv_pkg::muldiv_op_e op);
        return (op == muldiv_pkg::OP_DIV) || (op == muldiv_pkg::OP_DIVU);
    endfunction

    function automatic logic is_mf(input muldiv_pkg::muldiv_op_e op);
        return (op == muldiv_pkg::OP_MFHI) || (op == muldiv_pkg::OP_MFLO);
    endfunction

    // architectural effect of one op on the HI/LO model
    task automatic model_step(input muldiv_pkg::muldiv_op_e op, input muldiv_pkg::word_t a,
                              input muldiv_pkg::word_t b, output muldiv_pkg::word_t rd);
        longint          sa;
        longint          sb;
        longint unsigned ua;
        longint unsigned ub;
        logic [63:0]     res;
        sa = {{32{a[31]}}, a};
        sb = {{32{b[31]}}, b};
        ua = {32'b0, a};
        ub = {32'b0, b};
        rd = '0;
        case (op)
            muldiv_pkg::OP_MULT: begin
                res = sa * sb;
                model_hi = res[63:32];
                model_lo = res[31:0];
            end
            muldiv_pkg::OP_MULTU: begin
                res = ua * ub;
                model_hi = res[63:32];
                model_lo = res[31:0];
            end
            muldiv_pkg::OP_DIV, muldiv_pkg::OP_DIVU: begin
                if (b == '0) begin
                    model_hi = a;
                    model_lo = '1;
                end else if (op == muldiv_pkg::OP_DIV) begin
                    res = sa / sb;
                    model_lo = res[31:0];
                    res = sa % sb;
                    model_hi = res[31:0];
                end else begin
                    res = ua / ub;
                    model_lo = res[31:0];
                    res = ua % ub;
                    model_hi = res[31:0];
                end
            end
            muldiv_pkg::OP_MTHI: model_hi = a;
            muldiv_pkg::OP_MTLO: model_lo = a;
            muldiv_pkg::OP_MFHI: rd = model_hi;
            muldiv_pkg::OP_MFLO: rd = model_lo;
            default: rd = '0;
        endcase
    endtask

    task automatic add_row(input muldiv_pkg::muldiv_op_e op, input muldiv_pkg::word_t a,
                           input muldiv_pkg::word_t b);
        muldiv_pkg::word_t rd;
        model_step(op, a, b, rd);
        tbl_op.push_back(op);
        tbl_a.push_back(a);
        tbl_b.push_back(b);
        tbl_hi.push_back(model_hi);
        tbl_lo.push_back(model_lo);
        tbl_rd.push_back(rd);
    endtask

    task automatic check_word(input string name, input muldiv_pkg::word_t got,
                              input muldiv_pkg::word_t exp);
        if (got !== exp) begin
            $display("ERROR %s got 0x%08h expected 0x%08h", name, got, exp);
            $display("** FAIL **");
            $fatal(1, "result mismatch");
        end
    endtask

    task automatic check_hilo(input muldiv_pkg::word_t got_hi, input muldiv_pkg::word_t got_lo,
                              input muldiv_pkg::word_t exp_h, input muldiv_pkg::word_t exp_l);
        if ((got_hi !== exp_h) || (got_lo !== exp_l)) begin
            $display("ERROR hi_o/lo_o got 0x%08h/0x%08h expected 0x%08h/0x%08h",
                     got_hi, got_lo, exp_h, exp_l);
            $display("** FAIL **");
            $fatal(1, "HI/LO mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR %s got 0x%0h expected 0x%0h", name, got, exp);
            $display("** FAIL **");
            $fatal(1, "control mismatch");
        end
    endtask

    task automatic drive_row(input int idx);
        op_valid_i = 1'b1;
        op_i       = tbl_op[idx];
        opnd_a_i   = tbl_a[idx];
        opnd_b_i   = tbl_b[idx];
    endtask

    // called at the first falling edge after a divide was taken
    task automatic finish_divide(input int row);
        check_bit("stall_o", stall_o, 1'b1);
        while (stall_o) begin
            @(negedge clk);
        end
        // result enters wb at the next edge and HI/LO one edge later
        exp_hi[cyc + 2] = tbl_hi[row];
        exp_lo[cyc + 2] = tbl_lo[row];
    endtask

    always @(negedge clk) begin
        if (checking) begin
            check_bit("rd_valid_o", rd_valid_o, exp_rd.exists(cyc) != 0);
            if (exp_rd.exists(cyc)) begin
                check_word("rd_data_o", rd_data_o, exp_rd[cyc]);
                exp_rd.delete(cyc);
            end
            if (exp_hi.exists(cyc)) begin
                check_hilo(hi_o, lo_o, exp_hi[cyc], exp_lo[cyc]);
                exp_hi.delete(cyc);
                exp_lo.delete(cyc);
            end
        end
    end

    initial begin
        wait (table_ready);
        repeat (tbl_op.size() * (muldiv_pkg::DIV_CYCLES + 10) + 20) @(posedge clk);
        $display("timeout: the DUT did not get through the stimulus table in time");
        $display("** FAIL **");
        $fatal(1, "watchdog expired");
    end

    initial begin
        int                c0;
        int                div_row;
        logic              div_pending;
        logic [3:0]        sel4;
        muldiv_pkg::word_t ra;
        muldiv_pkg::word_t rb;
        void'($urandom(32'h9400));
        arst_n_i   = 1'b0;
        op_valid_i = 1'b0;
        op_i       = muldiv_pkg::OP_NOP;
        opnd_a_i   = '0;
        opnd_b_i   = '0;

        // forwarding right after each kind of HI/LO write
        add_row(muldiv_pkg::OP_MTHI, 32'h1234_5678, 32'h0);
        add_row(muldiv_pkg::OP_MFHI, 32'h0, 32'h0);
        add_row(muldiv_pkg::OP_MTLO, 32'h9abc_def0, 32'h0);
        add_row(muldiv_pkg::OP_MFLO, 32'h0, 32'h0);
        add_row(muldiv_pkg::OP_MFHI, 32'h0, 32'h0);
        add_row(muldiv_pkg::OP_MULT, 32'h8000_0000, 32'h8000_0000);
        add_row(muldiv_pkg::OP_MFHI, 32'h0, 32'h0);
        add_row(muldiv_pkg::OP_MULT, 32'hffff_ffff, 32'h0000_0002);
        add_row(muldiv_pkg::OP_MFLO, 32'h0, 32'h0);
        add_row(muldiv_pkg::OP_MULTU, 32'hffff_ffff, 32'hffff_ffff);
        add_row(muldiv_pkg::OP_MULT, 32'h7fff_ffff, 32'h8000_0000);
        // divides with reads that wait out the stall
        add_row(muldiv_pkg::OP_DIV, 32'hffff_ff9c, 32'd7);
        add_row(muldiv_pkg::OP_MFLO, 32'h0, 32'h0);
        add_row(muldiv_pkg::OP_MFHI, 32'h0, 32'h0);
        add_row(muldiv_pkg::OP_DIVU, 32'hffff_ff9c, 32'd7);
        add_row(muldiv_pkg::OP_DIV, 32'd100, 32'hffff_fff9);
        add_row(muldiv_pkg::OP_DIV, 32'h1234_5678, 32'd0);
        add_row(muldiv_pkg::OP_DIVU, 32'h8000_0001, 32'd0);
        add_row(muldiv_pkg::OP_DIV, 32'h8000_0000, 32'hffff_ffff);
        add_row(muldiv_pkg::OP_MFHI, 32'h0, 32'h0);
        add_row(muldiv_pkg::OP_MTHI, 32'hcafe_0001, 32'h0);
        add_row(muldiv_pkg::OP_MTLO, 32'h0bad_f00d, 32'h0);
        add_row(muldiv_pkg::OP_MFHI, 32'h0, 32'h0);
        repeat (14) begin
            sel4 = 4'($urandom % 8) + 4'd1;
            ra   = $urandom;
            rb   = $urandom >> ($urandom % 28);
            add_row(muldiv_pkg::muldiv_op_e'(sel4), ra, rb);
        end
        table_ready = 1'b1;

        repeat (10) @(negedge clk);
        arst_n_i = 1'b1;
        @(negedge clk);
        check_hilo(hi_o, lo_o, '0, '0);
        check_bit("rd_valid_o", rd_valid_o, 1'b0);
        check_bit("stall_o", stall_o, 1'b0);
        checking    = 1'b1;
        div_pending = 1'b0;
        div_row     = 0;

        for (int i = 0; i < tbl_op.size(); i++) begin
            @(negedge clk);
            drive_row(i);
            if (div_pending) begin
                finish_divide(div_row);
                div_pending = 1'b0;
            end else begin
                check_bit("stall_o", stall_o, 1'b0);
            end
            c0 = cyc;
            @(posedge clk);
            if (is_div(tbl_op[i])) begin
                div_pending = 1'b1;
                div_row     = i;
            end else begin
                exp_hi[c0 + 3] = tbl_hi[i];
                exp_lo[c0 + 3] = tbl_lo[i];
                if (is_mf(tbl_op[i])) begin
                    exp_rd[c0 + 2] = tbl_rd[i];
                end
            end
        end
        @(negedge clk);
        op_valid_i = 1'b0;
        if (div_pending) begin
            finish_divide(div_row);
        end
        while ((exp_rd.num() != 0) || (exp_hi.num() != 0)) begin
            @(negedge clk);
        end
        $display("** PASS **");
        $finish;
    end

endmodule

/* project.f */
rtl/muldiv_pkg.sv
rtl/stage_reg.sv
rtl/pipe_control.sv
rtl/ex_stage.sv
rtl/div_unit.sv
rtl/hilo_regs.sv
rtl/muldiv_top.sv
sim/muldiv_properties.sv
sim/tb_muldiv.sv

/* run.sh */
#!/bin/sh
# build and run the testbench with Verilator, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f project.f --top-module tb_muldiv -o tb_muldiv \
    && ./obj_dir/tb_muldiv | tee sim.log \
    || { echo "verilator build or simulation run failed"; exit 1; }
grep -q '^\*\* PASS \*\*$' sim.log && exit 0 || exit 1
